// ==== Bender.yml ====
package:
  name: uncore

sources:
  - src/uncorePkg.sv
  - src/ahbSlaveIf.sv
  - src/ahbRegionSelect.sv
  - src/ahbRam.sv
  - src/clint.sv
  - src/uncore.sv
  - target: simulation
    files:
      - testbench/uncoreTb.sv

// ==== compile.f ====
src/uncorePkg.sv
src/ahbSlaveIf.sv
src/ahbRegionSelect.sv
src/ahbRam.sv
src/clint.sv
src/uncore.sv
testbench/uncoreTb.sv

// ==== src/ahbRam.sv ====
////////////////////////////////////////
// On-chip RAM slave
////////////////////////////////////////

`default_nettype none

module ahbRam (
  input  logic  HCLK,
  input  logic  rstN,
  ahbSlaveIf.slave bus
);

  // storage, 64 words
  logic [uncorePkg::xlen-1:0] mem [uncorePkg::ramWords];

  // address phase taken this cycle
  logic accept;
  // captured address-phase fields
  logic [uncorePkg::ramIdxW-1:0] wordIdxD;
  logic [1:0] byteOffD;
  logic [2:0] sizeD;
  logic writeD;
  // byte lanes touched by the pending write
  logic [3:0] laneEn;

  // only NONSEQ and SEQ carry a transfer
  assign accept = bus.hSel && bus.hReadyIn &&
                  (bus.hTrans == uncorePkg::transNonseq ||
                   bus.hTrans == uncorePkg::transSeq);

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////

  // pending-write flag, cleared when nothing is accepted
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      writeD <= 1'b0;
    end else if (bus.hReadyIn) begin
      writeD <= accept & bus.hWrite;
    end
  end

  // address fields, only meaningful while writeD or a read is in flight
  always_ff @(posedge HCLK) begin
    if (accept) begin
      wordIdxD <= bus.hAddr[uncorePkg::ramIdxW+1:2];
      byteOffD <= bus.hAddr[1:0];
      sizeD    <= bus.hSize;
    end
  end

  ////////////////////////////////////////
  // data phase
  ////////////////////////////////////////

  // lane rule: byte picks one lane, halfword picks a pair
  always_comb begin
    case (sizeD)
      3'd0:    laneEn = 4'b0001 << byteOffD;
      3'd1:    laneEn = byteOffD[1] ? 4'b1100 : 4'b0011;
      default: laneEn = 4'b1111;
    endcase
  end

  // write lands at the end of the data phase
  always_ff @(posedge HCLK) begin
    if (writeD && bus.hReadyIn) begin
      for (int i = 0; i < 4; i++) begin
        if (laneEn[i]) begin
          mem[wordIdxD][8*i +: 8] <= bus.hWData[8*i +: 8];
        end
      end
    end
  end

  // full word out, subword extraction is left to the master
  assign bus.hRData = mem[wordIdxD];

  // zero wait states, never errors
  assign bus.hReadyOut = 1'b1;
  assign bus.hResp     = 1'b0;

endmodule

`default_nettype wire

// ==== src/ahbRegionSelect.sv ====
////////////////////////////////////////
// AHB-Lite decode and response mux
////////////////////////////////////////

`default_nettype none

module ahbRegionSelect (
  input  logic                         HCLK,
  input  logic                         rstN,
  // bus from the core
  input  logic [uncorePkg::addrW-1:0]  hAddr,
  input  logic [2:0]                   hSize,
  input  logic                         hWrite,
  input  uncorePkg::ahbTransE          hTrans,
  input  logic [uncorePkg::xlen-1:0]   hWData,
  output logic [uncorePkg::xlen-1:0]   hRData,
  output logic                         hReady,
  output logic                         hResp,
  // per-slave bundles
  ahbSlaveIf.master                    ramBus,
  ahbSlaveIf.master                    clintBus
);

  // address-phase decode
  uncorePkg::regionSelT sel;
  // same decode, held for the data phase
  uncorePkg::regionSelT selD;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // a region hits when the bits above its mask equal the base
  always_comb begin
    sel.ram   = (hAddr & ~uncorePkg::ramRange) == uncorePkg::ramBase;
    sel.clint = (hAddr & ~uncorePkg::clintRange) == uncorePkg::clintBase;
    // unmapped, answered here with an OKAY
    sel.none  = ~(sel.ram | sel.clint);
  end

  ////////////////////////////////////////
  // fan out to the slaves
  ////////////////////////////////////////

  // RAM bundle
  assign ramBus.hSel     = sel.ram;
  assign ramBus.hAddr    = hAddr;
  assign ramBus.hSize    = hSize;
  assign ramBus.hWrite   = hWrite;
  assign ramBus.hTrans   = hTrans;
  assign ramBus.hWData   = hWData;
  assign ramBus.hReadyIn = hReady;

  // CLINT bundle
  assign clintBus.hSel     = sel.clint;
  assign clintBus.hAddr    = hAddr;
  assign clintBus.hSize    = hSize;
  assign clintBus.hWrite   = hWrite;
  assign clintBus.hTrans   = hTrans;
  assign clintBus.hWData   = hWData;
  assign clintBus.hReadyIn = hReady;

  ////////////////////////////////////////
  // data-phase select
  ////////////////////////////////////////

  // address phase to data phase delay, only advances with the bus
  // reset to none so the bus comes up ready
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      selD <= '{ram: 1'b0, clint: 1'b0, none: 1'b1};
    end else if (hReady) begin
      selD <= sel;
    end
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////

  // selD is one-hot so an AND-OR is enough
  assign hRData = ({uncorePkg::xlen{selD.ram}}   & ramBus.hRData) |
                  ({uncorePkg::xlen{selD.clint}} & clintBus.hRData);

  // unmapped data phase finishes at once
  assign hReady = (selD.ram   & ramBus.hReadyOut) |
                  (selD.clint & clintBus.hReadyOut) |
                  selD.none;

  // no error for unmapped space
  assign hResp = (selD.ram   & ramBus.hResp) |
                 (selD.clint & clintBus.hResp);

endmodule

`default_nettype wire

// ==== src/ahbSlaveIf.sv ====
////////////////////////////////////////
// AHB-Lite slave bundle
////////////////////////////////////////

`default_nettype none

interface ahbSlaveIf;

  // address and control, driven by the region select
  logic                          hSel;
  logic [uncorePkg::addrW-1:0]   hAddr;
  logic [2:0]                    hSize;
  logic                          hWrite;
  uncorePkg::ahbTransE           hTrans;
  // write data arrives one cycle after its address
  logic [uncorePkg::xlen-1:0]    hWData;
  // bus-wide ready, tells the slave when an address phase is taken
  logic                          hReadyIn;

  // response from the slave
  logic [uncorePkg::xlen-1:0]    hRData;
  logic                          hReadyOut;
  logic                          hResp;

  // decoder / mux side
  modport master (
    output hSel, hAddr, hSize, hWrite, hTrans, hWData, hReadyIn,
    input  hRData, hReadyOut, hResp
  );

  // peripheral side
  modport slave (
    input  hSel, hAddr, hSize, hWrite, hTrans, hWData, hReadyIn,
    output hRData, hReadyOut, hResp
  );

endinterface

`default_nettype wire

// ==== src/clint.sv ====
////////////////////////////////////////
// Core-local interruptor
////////////////////////////////////////

`default_nettype none

module clint (
  input  logic        HCLK,
  input  logic        rstN,
  ahbSlaveIf.slave    bus,
  output logic        timerIntM,
  output logic        swIntM,
  output logic [63:0] mtime
);

  // two-cycle error response
  typedef enum logic [1:0] {
    errIdle,
    errFirst,
    errSecond
  } errStateE;

  errStateE errState;
  logic accept;
  logic offOk;
  // captured address phase
  logic [15:0] offD;
  logic writeD;
  // registers
  logic        msip;
  logic [63:0] mtimecmp;
  // per-register write strobes for the data phase
  logic wrMsip;
  logic wrCmpLo;
  logic wrCmpHi;
  logic wrTimeLo;
  logic wrTimeHi;

  assign accept = bus.hSel && bus.hReadyIn &&
                  (bus.hTrans == uncorePkg::transNonseq ||
                   bus.hTrans == uncorePkg::transSeq);

  // implemented offsets, anything else in the window errors
  always_comb begin
    case (bus.hAddr[15:0])
      uncorePkg::msipOff,
      uncorePkg::mtimecmpOff, uncorePkg::mtimecmpOff + 16'd4,
      uncorePkg::mtimeOff, uncorePkg::mtimeOff + 16'd4: offOk = 1'b1;
      default: offOk = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////

  // a bad offset never sets writeD, so nothing changes while erroring
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      writeD <= 1'b0;
    end else if (bus.hReadyIn) begin
      writeD <= accept & bus.hWrite & offOk;
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      offD <= bus.hAddr[15:0];
    end
  end

  // error FSM
  // first data cycle stalls the bus, second one completes it
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      errState <= errIdle;
    end else begin
      case (errState)
        errFirst: errState <= errSecond;
        default:  errState <= (accept && !offOk) ? errFirst : errIdle;
      endcase
    end
  end

  assign bus.hReadyOut = (errState != errFirst);
  assign bus.hResp     = (errState != errIdle);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_comb begin
    wrMsip   = writeD && offD == uncorePkg::msipOff;
    wrCmpLo  = writeD && offD == uncorePkg::mtimecmpOff;
    wrCmpHi  = writeD && offD == uncorePkg::mtimecmpOff + 16'd4;
    wrTimeLo = writeD && offD == uncorePkg::mtimeOff;
    wrTimeHi = writeD && offD == uncorePkg::mtimeOff + 16'd4;
  end

  // only bit 0 of msip exists
  // mtimecmp comes up all ones so no timer interrupt fires after reset
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      msip     <= 1'b0;
      mtimecmp <= '1;
      mtime    <= '0;
    end else begin
      if (wrMsip) msip <= bus.hWData[0];
      if (wrCmpLo) mtimecmp[31:0] <= bus.hWData;
      if (wrCmpHi) mtimecmp[63:32] <= bus.hWData;
      // mtime counts HCLK, a write takes the place of the increment
      if (wrTimeLo) begin
        mtime[31:0] <= bus.hWData;
      end else if (wrTimeHi) begin
        mtime[63:32] <= bus.hWData;
      end else begin
        mtime <= mtime + 64'd1;
      end
    end
  end

  // read mux, unimplemented offsets read as zero
  always_comb begin
    case (offD)
      uncorePkg::msipOff:             bus.hRData = {31'd0, msip};
      uncorePkg::mtimecmpOff:         bus.hRData = mtimecmp[31:0];
      uncorePkg::mtimecmpOff + 16'd4: bus.hRData = mtimecmp[63:32];
      uncorePkg::mtimeOff:            bus.hRData = mtime[31:0];
      uncorePkg::mtimeOff + 16'd4:    bus.hRData = mtime[63:32];
      default:                        bus.hRData = '0;
    endcase
  end

  ////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////

  assign timerIntM = (mtime >= mtimecmp);
  assign swIntM    = msip;

endmodule

`default_nettype wire

// ==== src/uncore.sv ====
////////////////////////////////////////
// Uncore top level
////////////////////////////////////////

`default_nettype none

module uncore (
  input  logic                         HCLK,
  input  logic                         rstN,
  // AHB-Lite bus from the core
  input  logic [uncorePkg::addrW-1:0]  hAddr,
  input  logic [2:0]                   hSize,
  input  logic                         hWrite,
  input  uncorePkg::ahbTransE          hTrans,
  input  logic [uncorePkg::xlen-1:0]   hWData,
  output logic [uncorePkg::xlen-1:0]   hRData,
  output logic                         hReady,
  output logic                         hResp,
  // interrupts and time to the core
  output logic                         timerIntM,
  output logic                         swIntM,
  output logic [63:0]                  mtime
);

  // one bundle per slave
  ahbSlaveIf ramBus ();
  ahbSlaveIf clintBus ();

  // decode, data-phase select and response mux
  ahbRegionSelect regionSel (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .hAddr    (hAddr),
    .hSize    (hSize),
    .hWrite   (hWrite),
    .hTrans   (hTrans),
    .hWData   (hWData),
    .hRData   (hRData),
    .hReady   (hReady),
    .hResp    (hResp),
    .ramBus   (ramBus),
    .clintBus (clintBus)
  );

  // 64-word RAM at ramBase
  ahbRam ram (
    .HCLK (HCLK),
    .rstN (rstN),
    .bus  (ramBus)
  );

  // timer and software interrupt
  clint clint (
    .HCLK      (HCLK),
    .rstN      (rstN),
    .bus       (clintBus),
    .timerIntM (timerIntM),
    .swIntM    (swIntM),
    .mtime     (mtime)
  );

endmodule

`default_nettype wire

// ==== src/uncorePkg.sv ====
////////////////////////////////////////
// Uncore shared definitions
////////////////////////////////////////

`default_nettype none

package uncorePkg;

  // bus widths
  localparam int xlen  = 32;
  localparam int addrW = 32;

  // AHB-Lite transfer types, bit 1 set means a real transfer
  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } ahbTransE;

  ////////////////////////////////////////
  // memory map
  ////////////////////////////////////////

  // on-chip RAM, 256 bytes
  localparam logic [addrW-1:0] ramBase  = 32'h8000_0000;
  localparam logic [addrW-1:0] ramRange = 32'h0000_00FF;
  localparam int ramWords = 64;
  localparam int ramIdxW  = $clog2(ramWords);

  // CLINT, 64 KiB window
  localparam logic [addrW-1:0] clintBase  = 32'h0200_0000;
  localparam logic [addrW-1:0] clintRange = 32'h0000_FFFF;

  // CLINT register offsets, high halves sit at offset plus 4
  localparam logic [15:0] msipOff     = 16'h0000;
  localparam logic [15:0] mtimecmpOff = 16'h4000;
  localparam logic [15:0] mtimeOff    = 16'hBFF8;

  // one-hot region select, none keeps the bus alive
  typedef struct packed {
    logic ram;
    logic clint;
    logic none;
  } regionSelT;

endpackage

`default_nettype wire

// ==== testbench/uncoreTb.sv ====
////////////////////////////////////////
// Uncore directed testbench
////////////////////////////////////////

`default_nettype none

module uncoreTb;

  // cycle budgets per test
  // their sum sets the watchdog
  localparam int resetBudget  = 20;
  localparam int ramBudget    = 120;
  localparam int laneBudget   = 80;
  localparam int errBudget    = 30;
  localparam int swBudget     = 30;
  localparam int timerBudget  = 320;
  localparam int marginBudget = 100;
  localparam int totalBudget  = resetBudget + ramBudget + laneBudget + errBudget +
                                swBudget + timerBudget + marginBudget;

  logic                        HCLK;
  logic                        rstN;
  logic [uncorePkg::addrW-1:0] hAddr;
  logic [2:0]                  hSize;
  logic                        hWrite;
  uncorePkg::ahbTransE         hTrans;
  logic [uncorePkg::xlen-1:0]  hWData;
  logic [uncorePkg::xlen-1:0]  hRData;
  logic                        hReady;
  logic                        hResp;
  logic                        timerIntM;
  logic                        swIntM;
  logic [63:0]                 mtime;

  // reference image of the RAM
  logic [uncorePkg::xlen-1:0] refMem [uncorePkg::ramWords];
  // a word known to hold valid data
  logic [5:0] knownIdx;
  logic [15:0] lfsrState;
  // queues of the pipelined run
  logic [uncorePkg::addrW-1:0] addrQ [$];
  logic [uncorePkg::xlen-1:0]  dataQ [$];
  logic                        respQ [$];

  uncore dut (.*);

  always #50 HCLK = ~HCLK;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic logic [uncorePkg::addrW-1:0] ramAddr(input logic [5:0] idx);
    return uncorePkg::ramBase + {idx, 2'b00};
  endfunction

  function automatic logic [uncorePkg::addrW-1:0] clintAddr(input logic [15:0] off);
    return uncorePkg::clintBase + off;
  endfunction

  // expected word after a subword write
  function automatic logic [uncorePkg::xlen-1:0] laneMerge(
    input logic [uncorePkg::xlen-1:0] old,
    input logic [uncorePkg::xlen-1:0] data,
    input logic [2:0] size,
    input logic [1:0] off
  );
    logic [uncorePkg::xlen-1:0] r;
    logic hit;
    r = old;
    for (int b = 0; b < 4; b++) begin
      hit = (size == 3'd2) || (size == 3'd1 && b[1] == off[1]) ||
            (size == 3'd0 && b == off);
      if (hit) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkData(input logic [uncorePkg::xlen-1:0] got,
                           input logic [uncorePkg::xlen-1:0] exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED at time %0t: %s, got %h expected %h",
                        $time, what, got, exp));
    end
  endtask

  task automatic checkResp(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED at time %0t: %s, got %b expected %b",
                        $time, what, got, exp));
    end
  endtask

  task automatic checkLevel(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED at time %0t: %s, level %b expected %b",
                        $time, what, got, exp));
    end
  endtask

  // 64-bit timer value on the mtime port
  task automatic checkTime(input logic [63:0] got, input logic [63:0] exp,
                           input string what);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED at time %0t: %s, got %0d expected %0d",
                        $time, what, got, exp));
    end
  endtask

  // mtime read-back lies in a window
  task automatic checkRange(input logic [uncorePkg::xlen-1:0] got,
                            input int lo, input int hi, input string what);
    if (got < lo || got >= hi) begin
      failRun($sformatf("CHECK FAILED at time %0t: %s, got %0d outside [%0d, %0d)",
                        $time, what, got, lo, hi));
    end
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  task automatic ahbWrite(input logic [uncorePkg::addrW-1:0] addr, input logic [2:0] size,
                          input logic [uncorePkg::xlen-1:0] data);
    @(posedge HCLK);
    hAddr  <= addr;
    hSize  <= size;
    hWrite <= 1'b1;
    hTrans <= uncorePkg::transNonseq;
    @(posedge HCLK);
    // write data follows its address by one cycle
    hTrans <= uncorePkg::transIdle;
    hWrite <= 1'b0;
    hWData <= data;
    @(negedge HCLK);
    while (!hReady) @(negedge HCLK);
  endtask

  // firstReady is hReady in the first data-phase cycle
  task automatic ahbRead(input logic [uncorePkg::addrW-1:0] addr,
                         output logic [uncorePkg::xlen-1:0] data,
                         output logic resp, output logic firstReady);
    @(posedge HCLK);
    hAddr  <= addr;
    hSize  <= 3'd2;
    hWrite <= 1'b0;
    hTrans <= uncorePkg::transNonseq;
    @(posedge HCLK);
    hTrans <= uncorePkg::transIdle;
    @(negedge HCLK);
    firstReady = hReady;
    while (!hReady) @(negedge HCLK);
    data = hRData;
    resp = hResp;
  endtask

  // back-to-back word reads of addrQ
  // address i sits on the bus during the data phase of i-1
  task automatic ahbPipelined();
    int n;
    n = addrQ.size();
    dataQ.delete();
    respQ.delete();
    @(posedge HCLK);
    for (int i = 0; i <= n; i++) begin
      if (i < n) begin
        hAddr  <= addrQ[i];
        hSize  <= 3'd2;
        hWrite <= 1'b0;
        hTrans <= uncorePkg::transNonseq;
      end else begin
        hTrans <= uncorePkg::transIdle;
      end
      if (i > 0) begin
        // stalls keep address i held
        @(negedge HCLK);
        while (!hReady) @(negedge HCLK);
        dataQ.push_back(hRData);
        respQ.push_back(hResp);
      end
      if (i < n) begin
        @(posedge HCLK);
      end
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic resetLevels();
    @(negedge HCLK);
    checkResp(hReady, 1'b1, "hReady after reset");
    checkResp(hResp, 1'b0, "hResp after reset");
    checkLevel(timerIntM, 1'b0, "timerIntM after reset");
    checkLevel(swIntM, 1'b0, "swIntM after reset");
  endtask

  task automatic ramWordTraffic();
    logic [5:0] idx;
    logic [uncorePkg::xlen-1:0] data;
    addrQ.delete();
    for (int i = 0; i < 12; i++) begin
      idx  = 6'(randBits(6));
      data = randBits(32);
      ahbWrite(ramAddr(idx), 3'd2, data);
      refMem[idx] = data;
      addrQ.push_back(ramAddr(idx));
    end
    ahbPipelined();
    for (int i = 0; i < addrQ.size(); i++) begin
      checkData(dataQ[i], refMem[addrQ[i][7:2]], "pipelined RAM read");
      checkResp(respQ[i], 1'b0, "pipelined RAM hResp");
    end
  endtask

  task automatic ramLaneWrites();
    logic [uncorePkg::xlen-1:0] data;
    logic [uncorePkg::xlen-1:0] rd;
    logic resp;
    logic rdy;
    logic [2:0] size;
    logic [1:0] off;
    knownIdx = 6'(randBits(6));
    data = randBits(32);
    ahbWrite(ramAddr(knownIdx), 3'd2, data);
    refMem[knownIdx] = data;
    // four bytes and then the two halfwords
    for (int k = 0; k < 6; k++) begin
      size = (k < 4) ? 3'd0 : 3'd1;
      off  = (k < 4) ? 2'(k) : 2'((k - 4) * 2);
      data = randBits(32);
      ahbWrite(ramAddr(knownIdx) + off, size, data);
      refMem[knownIdx] = laneMerge(refMem[knownIdx], data, size, off);
      ahbRead(ramAddr(knownIdx), rd, resp, rdy);
      checkData(rd, refMem[knownIdx], $sformatf("subword write size %0d off %0d", size, off));
    end
  endtask

  task automatic unmappedAndError();
    logic [uncorePkg::xlen-1:0] rd;
    logic resp;
    logic rdy;
    ahbRead(32'h4000_0000, rd, resp, rdy);
    checkData(rd, '0, "unmapped read data");
    checkResp(resp, 1'b0, "unmapped hResp");
    // offset 0x10 is inside the CLINT but not implemented
    ahbRead(clintAddr(16'h0010), rd, resp, rdy);
    checkResp(rdy, 1'b0, "hReady in first error cycle");
    checkResp(resp, 1'b1, "CLINT error hResp");
    ahbRead(ramAddr(knownIdx), rd, resp, rdy);
    checkData(rd, refMem[knownIdx], "RAM read after error");
  endtask

  task automatic softwareInterrupt();
    logic [uncorePkg::xlen-1:0] rd;
    logic resp;
    logic rdy;
    ahbWrite(clintAddr(uncorePkg::msipOff), 3'd2, 32'd1);
    @(posedge HCLK);
    @(negedge HCLK);
    checkLevel(swIntM, 1'b1, "swIntM after msip set");
    ahbRead(clintAddr(uncorePkg::msipOff), rd, resp, rdy);
    checkData(rd, 32'd1, "msip read after set");
    ahbWrite(clintAddr(uncorePkg::msipOff), 3'd2, 32'd0);
    @(posedge HCLK);
    @(negedge HCLK);
    checkLevel(swIntM, 1'b0, "swIntM after msip clear");
    ahbRead(clintAddr(uncorePkg::msipOff), rd, resp, rdy);
    checkData(rd, 32'd0, "msip read after clear");
  endtask

  task automatic timerInterrupt();
    logic [uncorePkg::xlen-1:0] rd;
    logic resp;
    logic rdy;
    int waited;
    ahbWrite(clintAddr(uncorePkg::mtimeOff), 3'd2, 32'd0);
    ahbWrite(clintAddr(uncorePkg::mtimeOff + 16'd4), 3'd2, 32'd0);
    // high word first so the compare never dips low in between
    ahbWrite(clintAddr(uncorePkg::mtimecmpOff + 16'd4), 3'd2, 32'd0);
    ahbWrite(clintAddr(uncorePkg::mtimecmpOff), 3'd2, 32'd200);
    @(posedge HCLK);
    @(negedge HCLK);
    checkLevel(timerIntM, 1'b0, "timerIntM right after mtimecmp write");
    waited = 0;
    while (!timerIntM && waited < 260) begin
      @(negedge HCLK);
      waited++;
    end
    checkLevel(timerIntM, 1'b1, "timerIntM within 260 cycles");
    // mtime steps by one per cycle so the first high level is at mtimecmp
    checkTime(mtime, 64'd200, "mtime port at timer interrupt");
    ahbRead(clintAddr(uncorePkg::mtimeOff), rd, resp, rdy);
    checkRange(rd, 200, 400, "mtime after timer interrupt");
    ahbWrite(clintAddr(uncorePkg::mtimecmpOff + 16'd4), 3'd2, '1);
    ahbWrite(clintAddr(uncorePkg::mtimecmpOff), 3'd2, '1);
    @(posedge HCLK);
    @(negedge HCLK);
    checkLevel(timerIntM, 1'b0, "timerIntM after mtimecmp rewrite");
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    HCLK      = 1'b0;
    rstN      = 1'b0;
    hAddr     = '0;
    hSize     = 3'd2;
    hWrite    = 1'b0;
    hTrans    = uncorePkg::transIdle;
    hWData    = '0;
    lfsrState = 16'd14645;
    repeat (16) @(posedge HCLK);
    rstN <= 1'b1;
    resetLevels();
    ramWordTraffic();
    ramLaneWrites();
    unmappedAndError();
    softwareInterrupt();
    timerInterrupt();
    $display("Testbench passed");
    $finish;
  end

  initial begin
    #(totalBudget * 100);
    failRun($sformatf("run timed out after %0d clock cycles", totalBudget));
  end

endmodule

`default_nettype wire
